// File: src/soc_bus_pkg.sv
// ------------------------------------------------------------
// SoC bus types
// Request and response words of the strobe bus, timer word
// ------------------------------------------------------------

package soc_bus_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // One-cycle request strobe, valid marks the cycle
  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  // Response arrives one cycle after the request
  typedef struct packed {
    logic                 rvalid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } word_halves_t;

  // 64-bit timer value, counted as a whole and accessed by halves
  typedef union packed {
    logic [63:0]  full;
    word_halves_t half;
  } mtime_word_t;

endpackage

// File: src/soc_map_pkg.sv
// ------------------------------------------------------------
// SoC address map
// Region indices, base addresses and CLINT register offsets
// ------------------------------------------------------------

package soc_map_pkg;

  // Decoder targets, RegionNone flags an unmapped access
  typedef enum logic [1:0] {
    RegionRom   = 2'd0,
    RegionClint = 2'd1,
    RegionNone  = 2'd2
  } region_e;

  // ------------------------------------------------------------
  // Boot ROM
  // ------------------------------------------------------------
  localparam logic [31:0] RomBase   = 32'h0001_0000;
  localparam logic [31:0] RomLength = 32'h0000_0040;
  localparam int unsigned RomWords  = 16;

  // ------------------------------------------------------------
  // CLINT
  // ------------------------------------------------------------
  localparam logic [31:0] ClintBase   = 32'h0200_0000;
  localparam logic [31:0] ClintLength = 32'h0000_C000;

  // One msip word per hart
  localparam logic [31:0] MsipOffset = 32'h0000_0000;
  localparam logic [31:0] MsipStride = 32'd4;

  // Per-hart compare, lo word first then hi
  localparam logic [31:0] MtimecmpOffset = 32'h0000_4000;
  localparam logic [31:0] MtimecmpStride = 32'd8;

  // Shared machine timer
  localparam logic [31:0] MtimeOffset   = 32'h0000_BFF8;
  localparam logic [31:0] MtimeHiOffset = 32'h0000_BFFC;

endpackage

// File: src/addr_decoder.sv
// ------------------------------------------------------------
// Address decoder
// Routes bus requests to ROM or CLINT and muxes the responses
// Unmapped accesses and ROM writes answer with an error
// ------------------------------------------------------------
`timescale 1ns/1ps

module addr_decoder (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  output soc_bus_pkg::bus_req_t rom_req_o,
  output soc_bus_pkg::bus_req_t clint_req_o,
  input  soc_bus_pkg::bus_rsp_t rom_rsp_i,
  input  soc_bus_pkg::bus_rsp_t clint_rsp_i
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  region_e region_sel;
  region_e region_q;
  logic    err_d;
  logic    err_q;

  always_comb begin
    if (req_i.addr >= RomBase && req_i.addr < RomBase + RomLength) begin
      region_sel = RegionRom;
    end else if (req_i.addr >= ClintBase && req_i.addr < ClintBase + ClintLength) begin
      region_sel = RegionClint;
    end else begin
      region_sel = RegionNone;
    end
  end

  // A write to the read-only ROM is refused here
  assign err_d = req_i.valid &
                 ((region_sel == RegionNone) || (region_sel == RegionRom && req_i.we));

  // Slaves see the offset into their own region
  always_comb begin
    rom_req_o         = req_i;
    rom_req_o.valid   = req_i.valid && region_sel == RegionRom && !req_i.we;
    rom_req_o.addr    = req_i.addr - RomBase;
    clint_req_o       = req_i;
    clint_req_o.valid = req_i.valid && region_sel == RegionClint;
    clint_req_o.addr  = req_i.addr - ClintBase;
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      region_q <= RegionNone;
      err_q    <= 1'b0;
    end else begin
      region_q <= req_i.valid ? region_sel : RegionNone;
      err_q    <= err_d;
    end
  end

  // Response mux one cycle after the request
  always_comb begin
    rsp_o = '0;
    if (err_q) begin
      rsp_o.rvalid = 1'b1;
      rsp_o.err    = 1'b1;
    end else begin
      unique case (region_q)
        RegionRom:   rsp_o = rom_rsp_i;
        RegionClint: rsp_o = clint_rsp_i;
        default:     rsp_o = '0;
      endcase
    end
  end

  // Every request is answered in the next cycle
  a_rsp_next: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    req_i.valid |=> rsp_o.rvalid);

endmodule

// File: src/boot_rom.sv
// ------------------------------------------------------------
// Boot ROM
// Read-only boot image with one-cycle registered read data
// ------------------------------------------------------------
`timescale 1ns/1ps

module boot_rom (
  input  logic                  clk_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o
);
  import soc_map_pkg::*;

  localparam int unsigned IdxWidth = $clog2(RomWords);

  logic [31:0]         mem [RomWords];
  logic [IdxWidth-1:0] word_idx;
  logic                rvalid_q;
  logic [31:0]         rdata_q;

  initial begin
    $readmemh("src/boot_rom.hex", mem);
  end

  // Byte offset to word index
  assign word_idx = req_i.addr[IdxWidth+1:2];

  always_ff @(posedge clk_i) begin
    rvalid_q <= req_i.valid;
    if (req_i.valid) begin
      rdata_q <= mem[word_idx];
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

  // The decoder turns ROM writes into errors upstream
  a_no_write: assert property (@(posedge clk_i) req_i.valid |-> !req_i.we);

endmodule

// File: src/clint_timer.sv
// ------------------------------------------------------------
// CLINT
// Machine timer, per-hart compare and msip registers, driving
// the timer and software interrupt lines
// ------------------------------------------------------------
`timescale 1ns/1ps

module clint_timer #(
  parameter int unsigned NumHarts = 2
) (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  input  logic                  rtc_tick_i,
  output logic [NumHarts-1:0]   timer_irq_o,
  output logic [NumHarts-1:0]   ipi_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  mtime_word_t                mtime_q;
  mtime_word_t [NumHarts-1:0] mtimecmp_q;
  logic [NumHarts-1:0]        msip_q;
  logic [NumHarts-1:0]        timer_irq_q;
  logic                       tick_div_q;
  logic                       mtime_inc;

  logic                 wr_en;
  logic                 mtime_lo_hit;
  logic                 mtime_hi_hit;
  logic [NumHarts-1:0]  msip_hit;
  logic [NumHarts-1:0]  cmp_lo_hit;
  logic [NumHarts-1:0]  cmp_hi_hit;
  logic [DataWidth-1:0] rdata_d;
  logic [DataWidth-1:0] rdata_q;
  logic                 rvalid_q;

  // ------------------------------------------------------------
  // Register decode
  // ------------------------------------------------------------
  assign wr_en        = req_i.valid & req_i.we;
  assign mtime_lo_hit = (req_i.addr == MtimeOffset);
  assign mtime_hi_hit = (req_i.addr == MtimeHiOffset);

  always_comb begin
    rdata_d = '0;
    for (int h = 0; h < NumHarts; h++) begin
      msip_hit[h]   = (req_i.addr == MsipOffset + MsipStride * 32'(h));
      cmp_lo_hit[h] = (req_i.addr == MtimecmpOffset + MtimecmpStride * 32'(h));
      cmp_hi_hit[h] = (req_i.addr == MtimecmpOffset + MtimecmpStride * 32'(h) + 32'd4);
      if (msip_hit[h])   rdata_d = {31'b0, msip_q[h]};
      if (cmp_lo_hit[h]) rdata_d = mtimecmp_q[h].half.lo;
      if (cmp_hi_hit[h]) rdata_d = mtimecmp_q[h].half.hi;
    end
    if (mtime_lo_hit) rdata_d = mtime_q.half.lo;
    if (mtime_hi_hit) rdata_d = mtime_q.half.hi;
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rdata_q <= req_i.we ? '0 : rdata_d;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

  // ------------------------------------------------------------
  // Timer, divide-by-two on the RTC tick
  // ------------------------------------------------------------
  assign mtime_inc = rtc_tick_i & tick_div_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      tick_div_q <= 1'b0;
      mtime_q    <= '0;
    end else begin
      if (rtc_tick_i) tick_div_q <= ~tick_div_q;
      // Bus write wins over the increment
      if (wr_en && mtime_lo_hit) begin
        mtime_q.half.lo <= req_i.wdata;
      end else if (wr_en && mtime_hi_hit) begin
        mtime_q.half.hi <= req_i.wdata;
      end else if (mtime_inc) begin
        mtime_q.full <= mtime_q.full + 64'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtimecmp_q  <= '1;
      msip_q      <= '0;
      timer_irq_q <= '0;
    end else begin
      for (int h = 0; h < NumHarts; h++) begin
        if (wr_en && cmp_lo_hit[h]) mtimecmp_q[h].half.lo <= req_i.wdata;
        if (wr_en && cmp_hi_hit[h]) mtimecmp_q[h].half.hi <= req_i.wdata;
        if (wr_en && msip_hit[h])   msip_q[h] <= req_i.wdata[0];
        timer_irq_q[h] <= (mtime_q.full >= mtimecmp_q[h].full);
      end
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

  // An unprogrammed compare must not fire before mtime wraps up to it
  for (genvar h = 0; h < NumHarts; h++) begin : g_irq_check
    a_idle_cmp: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
      (mtimecmp_q[h].full == '1 && mtime_q.full != '1) |=> !timer_irq_o[h]);
  end

endmodule

// File: src/debug_req_gate.sv
// ------------------------------------------------------------
// Debug request hold-off
// Blocks external debug requests for a fixed time after reset
// ------------------------------------------------------------
`timescale 1ns/1ps

module debug_req_gate #(
  parameter int unsigned NumHarts         = 2,
  parameter int unsigned DebugDelayCycles = 500
) (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  logic [NumHarts-1:0] debug_req_i,
  output logic [NumHarts-1:0] debug_req_o
);

  localparam int unsigned CntWidth = $clog2(DebugDelayCycles + 1);

  logic [CntWidth-1:0] cnt_q;
  logic                hold;

  // Window for boot code before the first debug halt
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CntWidth'(DebugDelayCycles);
    end else if (hold) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign hold        = (cnt_q != '0);
  assign debug_req_o = hold ? '0 : debug_req_i;

  // Once open the gate stays open until the next reset
  a_held_off: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !hold |=> !hold);

endmodule

// File: src/soc_subsystem.sv
// ------------------------------------------------------------
// SoC control subsystem
// Address decoder, boot ROM, CLINT and debug request hold-off
// ------------------------------------------------------------
`timescale 1ns/1ps

module soc_subsystem #(
  parameter int unsigned NumHarts         = 2,
  parameter int unsigned DebugDelayCycles = 500
) (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  input  logic                  rtc_tick_i,
  input  logic [NumHarts-1:0]   debug_req_i,
  output logic [NumHarts-1:0]   debug_req_o,
  output logic [NumHarts-1:0]   timer_irq_o,
  output logic [NumHarts-1:0]   ipi_o
);
  import soc_bus_pkg::*;

  bus_req_t rom_req;
  bus_rsp_t rom_rsp;
  bus_req_t clint_req;
  bus_rsp_t clint_rsp;

  // ------------------------------------------------------------
  // Bus
  // ------------------------------------------------------------
  addr_decoder i_addr_decoder (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .req_i       ( req_i      ),
    .rsp_o       ( rsp_o      ),
    .rom_req_o   ( rom_req    ),
    .clint_req_o ( clint_req  ),
    .rom_rsp_i   ( rom_rsp    ),
    .clint_rsp_i ( clint_rsp  )
  );

  boot_rom i_boot_rom (
    .clk_i ( clk_i   ),
    .req_i ( rom_req ),
    .rsp_o ( rom_rsp )
  );

  // ------------------------------------------------------------
  // Interrupts and timer
  // ------------------------------------------------------------
  clint_timer #(
    .NumHarts ( NumHarts )
  ) i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( clint_req   ),
    .rsp_o       ( clint_rsp   ),
    .rtc_tick_i  ( rtc_tick_i  ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // ------------------------------------------------------------
  // Debug
  // ------------------------------------------------------------
  debug_req_gate #(
    .NumHarts         ( NumHarts         ),
    .DebugDelayCycles ( DebugDelayCycles )
  ) i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: verification/tb_clock_gen.sv
// ------------------------------------------------------------
// Testbench clock and reset
// 4 ns clock, reset held low for the first five rising edges
// ------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic ndmreset_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release 1 ns after the fifth edge, in step with the stimulus
  initial begin
    ndmreset_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    #1;
    ndmreset_n_o = 1'b1;
  end

endmodule

// File: verification/tb_soc_subsystem.sv
// ------------------------------------------------------------
// SoC subsystem testbench
// Drives bus, RTC tick and debug requests, and checks every
// response against a reference model of the register map
// ------------------------------------------------------------
`timescale 1ns/1ps

module tb_soc_subsystem;
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int unsigned NumHarts   = 2;
  localparam int unsigned DebugDelay = 20;
  localparam int unsigned Timeout    = 200;

  logic                clk;
  logic                ndmreset_n;
  bus_req_t            req;
  bus_rsp_t            rsp;
  logic                rtc_tick;
  logic [NumHarts-1:0] debug_req_in;
  logic [NumHarts-1:0] debug_req_out;
  logic [NumHarts-1:0] timer_irq;
  logic [NumHarts-1:0] ipi;

  // Reference model state
  logic [31:0]         rom_image [RomWords];
  logic [63:0]         ref_mtime;
  logic [63:0]         ref_cmp [NumHarts];
  logic [NumHarts-1:0] ref_msip;
  logic [NumHarts-1:0] ref_irq;
  logic                ref_div;
  bus_rsp_t            exp_rsp;
  logic [31:0]         lfsr_q;

  tb_clock_gen i_tb_clock_gen (
    .clk_o        ( clk        ),
    .ndmreset_n_o ( ndmreset_n )
  );

  soc_subsystem #(
    .NumHarts         ( NumHarts   ),
    .DebugDelayCycles ( DebugDelay )
  ) i_soc_subsystem (
    .clk_i       ( clk           ),
    .ndmreset_n  ( ndmreset_n    ),
    .req_i       ( req           ),
    .rsp_o       ( rsp           ),
    .rtc_tick_i  ( rtc_tick      ),
    .debug_req_i ( debug_req_in  ),
    .debug_req_o ( debug_req_out ),
    .timer_irq_o ( timer_irq     ),
    .ipi_o       ( ipi           )
  );

  // ------------------------------------------------------------
  // Reporting and random numbers
  // ------------------------------------------------------------
  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, expected);
      stop_run("A checked value did not match");
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit drawn
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return r;
  endfunction

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic logic [31:0] clint_read(input logic [31:0] off);
    logic [31:0] val;
    val = '0;
    for (int h = 0; h < NumHarts; h++) begin
      if (off == MsipOffset + MsipStride * h) val = {31'b0, ref_msip[h]};
      if (off == MtimecmpOffset + MtimecmpStride * h) val = ref_cmp[h][31:0];
      if (off == MtimecmpOffset + MtimecmpStride * h + 4) val = ref_cmp[h][63:32];
    end
    if (off == MtimeOffset) val = ref_mtime[31:0];
    if (off == MtimeHiOffset) val = ref_mtime[63:32];
    return val;
  endfunction

  // Expected response one cycle after the request
  function automatic bus_rsp_t expected_rsp(input bus_req_t r);
    bus_rsp_t e;
    e = '0;
    if (r.valid) begin
      e.rvalid = 1'b1;
      if (r.addr - RomBase < RomLength) begin
        if (r.we) e.err = 1'b1;
        else e.rdata = rom_image[(r.addr - RomBase) >> 2];
      end else if (r.addr - ClintBase < ClintLength) begin
        if (!r.we) e.rdata = clint_read(r.addr - ClintBase);
      end else begin
        e.err = 1'b1;
      end
    end
    return e;
  endfunction

  task automatic apply_write(input bus_req_t r, output logic mtime_hit);
    logic [31:0] off;
    off = r.addr - ClintBase;
    mtime_hit = 1'b0;
    if (r.valid && r.we && off < ClintLength) begin
      for (int h = 0; h < NumHarts; h++) begin
        if (off == MsipOffset + MsipStride * h) ref_msip[h] = r.wdata[0];
        if (off == MtimecmpOffset + MtimecmpStride * h) ref_cmp[h][31:0] = r.wdata;
        if (off == MtimecmpOffset + MtimecmpStride * h + 4) ref_cmp[h][63:32] = r.wdata;
      end
      if (off == MtimeOffset) begin
        ref_mtime[31:0] = r.wdata;
        mtime_hit = 1'b1;
      end
      if (off == MtimeHiOffset) begin
        ref_mtime[63:32] = r.wdata;
        mtime_hit = 1'b1;
      end
    end
  endtask

  // Advanced at the same edge as the DUT, from pre-edge values
  always @(posedge clk) begin
    logic mtime_hit;
    if (!ndmreset_n) begin
      ref_mtime = '0;
      for (int h = 0; h < NumHarts; h++) ref_cmp[h] = '1;
      ref_msip = '0;
      ref_irq  = '0;
      ref_div  = 1'b0;
      exp_rsp  = '0;
    end else begin
      exp_rsp = expected_rsp(req);
      for (int h = 0; h < NumHarts; h++) ref_irq[h] = (ref_mtime >= ref_cmp[h]);
      apply_write(req, mtime_hit);
      // Every second tick advances the timer
      if (!mtime_hit && rtc_tick && ref_div) ref_mtime = ref_mtime + 64'd1;
      if (rtc_tick) ref_div = !ref_div;
    end
  end

  // Compare process, outputs are stable at the falling edge
  always @(negedge clk) begin
    if (ndmreset_n) begin
      check_value("rsp_o.rvalid", rsp.rvalid, exp_rsp.rvalid);
      check_value("rsp_o.err", rsp.err, exp_rsp.err);
      check_value("rsp_o.rdata", rsp.rdata, exp_rsp.rdata);
      check_value("timer_irq_o", timer_irq, ref_irq);
      check_value("ipi_o", ipi, ref_msip);
    end
  end

  // ------------------------------------------------------------
  // Stimulus, always driven 1 ns after the rising edge
  // ------------------------------------------------------------
  task automatic issue(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                       output bus_rsp_t r);
    req = '{valid: 1'b1, we: we, addr: addr, wdata: wdata};
    @(posedge clk);
    #1;
    r = rsp;
  endtask

  task automatic rtc_pulse();
    rtc_tick = 1'b1;
    @(posedge clk);
    #1;
    rtc_tick = 1'b0;
    @(posedge clk);
    #1;
  endtask

  initial begin
    $readmemh("src/boot_rom.hex", rom_image);
  end

  initial begin : stimulus
    bus_rsp_t    r;
    logic [31:0] addr;
    logic [63:0] wval;
    logic [63:0] cmp;
    logic [2:0]  sel;
    int unsigned n;
    int unsigned k_ticks;

    req          = '0;
    rtc_tick     = 1'b0;
    debug_req_in = '1;
    lfsr_q       = 32'hf9b4;

    n = 0;
    while (ndmreset_n !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > Timeout) stop_run("Timeout waiting for reset release");
    end

    // Debug hold-off, counted in edges after release
    check_value("debug_req_o", debug_req_out, '0);
    for (int k = 1; k <= DebugDelay + 3; k++) begin
      @(negedge clk);
      check_value("debug_req_o", debug_req_out, (k >= DebugDelay) ? 2'b11 : 2'b00);
    end
    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      #1;
      debug_req_in = rand_bits(2);
      @(negedge clk);
      check_value("debug_req_o", debug_req_out, debug_req_in);
    end
    @(posedge clk);
    #1;

    // ROM reads back to back, then refused accesses
    for (int i = 0; i < RomWords; i++) begin
      issue(1'b0, RomBase + 32'(4 * i), rand_bits(32), r);
      check_value("rsp_o.rdata", r.rdata, rom_image[i]);
    end
    issue(1'b1, RomBase + (rand_bits(4) << 2), rand_bits(32), r);
    check_value("rsp_o.err", r.err, 1'b1);
    for (int i = 0; i < 8; i++) begin
      addr = rand_bits(32);
      while ((addr - RomBase < RomLength) || (addr - ClintBase < ClintLength)) begin
        addr = rand_bits(32);
      end
      issue(rand_bits(1), addr, rand_bits(32), r);
      check_value("rsp_o.err", r.err, 1'b1);
      check_value("rsp_o.rdata", r.rdata, 32'h0);
    end
    req = '0;

    // Timer advance
    k_ticks = 5 + rand_bits(3);
    for (int i = 0; i < k_ticks; i++) rtc_pulse();
    issue(1'b0, ClintBase + MtimeOffset, '0, r);
    check_value("mtime lo", r.rdata, k_ticks / 2);
    issue(1'b0, ClintBase + MtimeHiOffset, '0, r);
    check_value("mtime hi", r.rdata, 32'h0);
    wval[63:32] = rand_bits(31);
    wval[31:0]  = rand_bits(32);
    issue(1'b1, ClintBase + MtimeOffset, wval[31:0], r);
    issue(1'b1, ClintBase + MtimeHiOffset, wval[63:32], r);
    req = '0;
    repeat (4) rtc_pulse();
    wval = wval + 64'd2;
    issue(1'b0, ClintBase + MtimeOffset, '0, r);
    check_value("mtime lo", r.rdata, wval[31:0]);
    issue(1'b0, ClintBase + MtimeHiOffset, '0, r);
    check_value("mtime hi", r.rdata, wval[63:32]);
    req = '0;

    // Timer interrupt per hart
    for (int h = 0; h < NumHarts; h++) begin
      cmp = ref_mtime + 64'd3 + rand_bits(3);
      issue(1'b1, ClintBase + MtimecmpOffset + 32'(8 * h + 4), cmp[63:32], r);
      issue(1'b1, ClintBase + MtimecmpOffset + 32'(8 * h), cmp[31:0], r);
      req = '0;
      n = 0;
      while (!timer_irq[h]) begin
        check_value("mtime below mtimecmp", ref_mtime < cmp, 1'b1);
        rtc_pulse();
        n++;
        if (n > Timeout) stop_run("Timeout waiting for the timer interrupt");
      end
      check_value("mtime at timer interrupt", ref_mtime >= cmp, 1'b1);
    end

    // Software interrupts set and clear one hart at a time
    for (int h = 0; h < NumHarts; h++) begin
      issue(1'b1, ClintBase + MsipOffset + 32'(4 * h), rand_bits(32) | 32'h1, r);
      req = '0;
      check_value("ipi_o", ipi, NumHarts'(1) << h);
      issue(1'b0, ClintBase + MsipOffset + 32'(4 * h), '0, r);
      check_value("msip readback", r.rdata, 32'h1);
      issue(1'b1, ClintBase + MsipOffset + 32'(4 * h), rand_bits(32) & ~32'h1, r);
      req = '0;
      check_value("ipi_o", ipi, '0);
      issue(1'b0, ClintBase + MsipOffset + 32'(4 * h), '0, r);
      check_value("msip readback", r.rdata, 32'h0);
    end

    // Random register traffic, back to back
    for (int i = 0; i < 48; i++) begin
      sel = rand_bits(3);
      if (sel[2]) addr = ClintBase + MsipOffset + 32'(4 * sel[1]);
      else addr = ClintBase + MtimecmpOffset + 32'(8 * sel[1] + 4 * sel[0]);
      issue(rand_bits(1), addr, rand_bits(32), r);
    end
    req = '0;
    @(posedge clk);
    #1;

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: sources.f
src/soc_bus_pkg.sv
src/soc_map_pkg.sv
src/addr_decoder.sv
src/boot_rom.sv
src/clint_timer.sv
src/debug_req_gate.sv
src/soc_subsystem.sv
verification/tb_clock_gen.sv
verification/tb_soc_subsystem.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_soc_subsystem
FILELIST  := sources.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: src/boot_rom.hex
// Boot ROM image, one 32-bit hex word per line
// Line n holds the word at byte offset 4*n from the ROM base
00000297
f1402573
00050463
10500073
020002b7
0002a023
00100293
30529073
00000517
03050513
7b351073
0000100f
00000013
ffdff06f
deadbeef
5a5a0f0f
